//--- design/frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// instruction buffer geometry.
`define IB_DEPTH       16
`define IB_DEPTH_LOG2  4

// a fetch block carries four 32-bit instructions.
`define FETCH_SLOTS    4
`define XLEN           32

// major opcodes that take part in the pairing rule.
`define OP_OP          7'b0110011
`define OP_IMM         7'b0010011

`endif

//--- design/frontend_pkg.sv
package frontend_pkg;

  // register-register layout of a base instruction.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // register-immediate layout with imm12 in place of funct7 and rs2.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  // one instruction word seen through either layout.
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_word_u;

endpackage

//--- design/fetch_align.sv
`timescale 1ns/10ps
`include "frontend_consts.svh"

module fetch_align import frontend_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush,
  input  logic                               fetch_valid,
  input  logic [`XLEN-1:0]                   fetch_pc,
  input  logic [`FETCH_SLOTS*`XLEN-1:0]      fetch_block,
  output logic [2:0]                         push_count,
  output instr_word_u [`FETCH_SLOTS-1:0]     push_lanes,
  output logic [`FETCH_SLOTS-1:0][`XLEN-1:0] push_pcs
);

  logic [1:0]                         slot_ofs;
  logic [`FETCH_SLOTS*`XLEN-1:0]      block_shifted;
  logic [`FETCH_SLOTS-1:0][`XLEN-1:0] lane_pcs;

  // the start pc selects the first live word inside the block.
  assign slot_ofs = fetch_pc[3:2];

  // shifting down by whole words drops the leading slots and packs the rest into lane 0 upward.
  assign block_shifted = fetch_block >> (slot_ofs * `XLEN);

  always_comb begin
    for (int k = 0; k < `FETCH_SLOTS; k++) begin
      lane_pcs[k] = fetch_pc + (k << 2);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      push_count <= 3'd0;
    end else if (fetch_valid) begin
      push_count <= 3'(`FETCH_SLOTS) - {1'b0, slot_ofs};
    end else begin
      push_count <= 3'd0;
    end
  end

  // lanes are only looked at while push_count is nonzero.
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      push_lanes <= block_shifted;
      push_pcs   <= lane_pcs;
    end
  end

  // fetch hands over word-aligned start addresses only.
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid |-> (fetch_pc[1:0] == 2'b00))
    else $error("fetch_align: misaligned fetch_pc %h", fetch_pc);

endmodule

//--- design/instr_buffer.sv
`timescale 1ns/10ps
`include "frontend_consts.svh"

module instr_buffer import frontend_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush,
  input  logic [2:0]                         push_count,
  input  instr_word_u [`FETCH_SLOTS-1:0]     push_lanes,
  input  logic [`FETCH_SLOTS-1:0][`XLEN-1:0] push_pcs,
  input  logic [1:0]                         pop_count,
  output logic [`IB_DEPTH_LOG2:0]            buf_count,
  output instr_word_u                        head_instr0,
  output instr_word_u                        head_instr1,
  output logic [`XLEN-1:0]                   head_pc0,
  output logic [`XLEN-1:0]                   head_pc1,
  output logic                               head_valid0,
  output logic                               head_valid1
);

  localparam int PTR_W = `IB_DEPTH_LOG2;

  instr_word_u      instr_mem [`IB_DEPTH];
  logic [`XLEN-1:0] pc_mem    [`IB_DEPTH];
  logic [PTR_W-1:0] head_ptr;
  logic [PTR_W-1:0] tail_ptr;
  logic [PTR_W-1:0] head_ptr_nxt;
  logic [PTR_W:0]   occupancy;
  logic [PTR_W:0]   count_next;

  // pushes and pops in the same cycle net out in the counter.
  assign count_next = occupancy + (PTR_W+1)'(push_count) - (PTR_W+1)'(pop_count);

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head_ptr  <= '0;
      tail_ptr  <= '0;
      occupancy <= '0;
    end else begin
      tail_ptr  <= tail_ptr + PTR_W'(push_count);
      head_ptr  <= head_ptr + PTR_W'(pop_count);
      occupancy <= count_next;
    end
  end

  // consecutive entries from the tail; the pointer wraps naturally at the depth.
  always_ff @(posedge clk) begin
    for (int k = 0; k < `FETCH_SLOTS; k++) begin
      if (k < int'(push_count)) begin
        instr_mem[tail_ptr + PTR_W'(k)] <= push_lanes[k];
        pc_mem[tail_ptr + PTR_W'(k)]    <= push_pcs[k];
      end
    end
  end

  assign head_ptr_nxt = head_ptr + PTR_W'(1);

  assign head_instr0 = instr_mem[head_ptr];
  assign head_instr1 = instr_mem[head_ptr_nxt];
  assign head_pc0    = pc_mem[head_ptr];
  assign head_pc1    = pc_mem[head_ptr_nxt];

  assign head_valid0 = (occupancy != '0);
  assign head_valid1 = (occupancy > (PTR_W+1)'(1));
  assign buf_count   = occupancy;

  // fetch watches buf_count and must never push past the depth.
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || flush)
    ((PTR_W+2)'(occupancy) + (PTR_W+2)'(push_count)
      <= (PTR_W+2)'(`IB_DEPTH) + (PTR_W+2)'(pop_count)))
    else $error("instr_buffer: overflow, count %0d push %0d pop %0d",
                occupancy, push_count, pop_count);

  // the decoder may only take entries that are really there.
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    ((PTR_W+1)'(pop_count) <= occupancy))
    else $error("instr_buffer: pop %0d from %0d entries", pop_count, occupancy);

endmodule

//--- design/pair_decoder.sv
`timescale 1ns/10ps
`include "frontend_consts.svh"

module pair_decoder import frontend_pkg::*; (
  input  instr_word_u      head_instr0,
  input  instr_word_u      head_instr1,
  input  logic [`XLEN-1:0] head_pc0,
  input  logic [`XLEN-1:0] head_pc1,
  input  logic             head_valid0,
  input  logic             head_valid1,
  input  logic             issue_ready,
  output logic [1:0]       pop_count,
  output logic             issue0_valid,
  output logic [`XLEN-1:0] issue0_pc,
  output instr_word_u      issue0_instr,
  output logic [4:0]       issue0_rd,
  output logic [4:0]       issue0_rs1,
  output logic [4:0]       issue0_rs2,
  output logic [`XLEN-1:0] issue0_imm,
  output logic             issue0_uses_imm,
  output logic             issue1_valid,
  output logic [`XLEN-1:0] issue1_pc,
  output instr_word_u      issue1_instr,
  output logic [4:0]       issue1_rd,
  output logic [4:0]       issue1_rs1,
  output logic [4:0]       issue1_rs2,
  output logic [`XLEN-1:0] issue1_imm,
  output logic             issue1_uses_imm
);

  function automatic logic is_alu(input logic [6:0] opcode);
    return (opcode == `OP_OP) || (opcode == `OP_IMM);
  endfunction

  // only OP-IMM carries an immediate here and everything else reads as zero.
  function automatic logic [`XLEN-1:0] imm_of(input instr_word_u w);
    if (w.i.opcode == `OP_IMM) begin
      return {{(`XLEN-12){w.i.imm12[11]}}, w.i.imm12};
    end else begin
      return '0;
    end
  endfunction

  logic rd0_live;
  logic rs1_hit;
  logic rs2_hit;
  logic slot1_blocked;

  // x0 is never a real destination, so writes to it cannot create a hazard.
  assign rd0_live = is_alu(head_instr0.r.opcode) && (head_instr0.r.rd != 5'd0);
  assign rs1_hit  = is_alu(head_instr1.r.opcode) && (head_instr1.r.rs1 == head_instr0.r.rd);
  assign rs2_hit  = (head_instr1.r.opcode == `OP_OP) && (head_instr1.r.rs2 == head_instr0.r.rd);

  assign slot1_blocked = rd0_live && (rs1_hit || rs2_hit);

  assign issue0_valid = issue_ready && head_valid0;
  assign issue1_valid = issue0_valid && head_valid1 && !slot1_blocked;
  assign pop_count    = {1'b0, issue0_valid} + {1'b0, issue1_valid};

  assign issue0_pc       = head_pc0;
  assign issue0_instr    = head_instr0;
  assign issue0_rd       = head_instr0.r.rd;
  assign issue0_rs1      = head_instr0.r.rs1;
  assign issue0_rs2      = head_instr0.r.rs2;
  assign issue0_imm      = imm_of(head_instr0);
  assign issue0_uses_imm = (head_instr0.i.opcode == `OP_IMM);

  assign issue1_pc       = head_pc1;
  assign issue1_instr    = head_instr1;
  assign issue1_rd       = head_instr1.r.rd;
  assign issue1_rs1      = head_instr1.r.rs1;
  assign issue1_rs2      = head_instr1.r.rs2;
  assign issue1_imm      = imm_of(head_instr1);
  assign issue1_uses_imm = (head_instr1.i.opcode == `OP_IMM);

  // slot 1 is the younger half of a pair only if the head fills in order.
  always_comb begin
    a_head_order: assert final (!(issue_ready && head_valid1) || head_valid0)
      else $error("pair_decoder: head entry 1 valid without entry 0");
  end

endmodule

//--- design/frontend_top.sv
`timescale 1ns/10ps
`include "frontend_consts.svh"

module frontend_top import frontend_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          fetch_valid,
  input  logic [`XLEN-1:0]              fetch_pc,
  input  logic [`FETCH_SLOTS*`XLEN-1:0] fetch_block,
  input  logic                          issue_ready,
  output logic [`IB_DEPTH_LOG2:0]       buf_count,
  output logic                          issue0_valid,
  output logic [`XLEN-1:0]              issue0_pc,
  output instr_word_u                   issue0_instr,
  output logic [4:0]                    issue0_rd,
  output logic [4:0]                    issue0_rs1,
  output logic [4:0]                    issue0_rs2,
  output logic [`XLEN-1:0]              issue0_imm,
  output logic                          issue0_uses_imm,
  output logic                          issue1_valid,
  output logic [`XLEN-1:0]              issue1_pc,
  output instr_word_u                   issue1_instr,
  output logic [4:0]                    issue1_rd,
  output logic [4:0]                    issue1_rs1,
  output logic [4:0]                    issue1_rs2,
  output logic [`XLEN-1:0]              issue1_imm,
  output logic                          issue1_uses_imm
);

  // aligner to buffer.
  logic [2:0]                         push_count;
  instr_word_u [`FETCH_SLOTS-1:0]     push_lanes;
  logic [`FETCH_SLOTS-1:0][`XLEN-1:0] push_pcs;

  // buffer head to decoder, and the pop count back.
  instr_word_u      head_instr0;
  instr_word_u      head_instr1;
  logic [`XLEN-1:0] head_pc0;
  logic [`XLEN-1:0] head_pc1;
  logic             head_valid0;
  logic             head_valid1;
  logic [1:0]       pop_count;

  // the three blocks share their port names with the wires above.
  fetch_align fetch_align_i (.*);

  instr_buffer instr_buffer_i (.*);

  pair_decoder pair_decoder_i (.*);

endmodule

//--- testbench/tb_frontend.sv
`timescale 1ns/10ps
`include "frontend_consts.svh"

module tb_frontend import frontend_pkg::*; ();

  localparam int          RESET_CYCLES   = 8;
  localparam int          RUN_CYCLES     = 3000;
  localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 6;
  localparam logic [15:0] SEED           = 16'd6203;

  logic                          clk;
  logic                          rst_n;
  logic                          flush;
  logic                          fetch_valid;
  logic [`XLEN-1:0]              fetch_pc;
  logic [`FETCH_SLOTS*`XLEN-1:0] fetch_block;
  logic                          issue_ready;
  logic [`IB_DEPTH_LOG2:0]       buf_count;
  logic                          issue0_valid;
  logic [`XLEN-1:0]              issue0_pc;
  instr_word_u                   issue0_instr;
  logic [4:0]                    issue0_rd;
  logic [4:0]                    issue0_rs1;
  logic [4:0]                    issue0_rs2;
  logic [`XLEN-1:0]              issue0_imm;
  logic                          issue0_uses_imm;
  logic                          issue1_valid;
  logic [`XLEN-1:0]              issue1_pc;
  instr_word_u                   issue1_instr;
  logic [4:0]                    issue1_rd;
  logic [4:0]                    issue1_rs1;
  logic [4:0]                    issue1_rs2;
  logic [`XLEN-1:0]              issue1_imm;
  logic                          issue1_uses_imm;

  // reference queue of the buffer, plus the block that sits in the aligner register.
  instr_word_u      q_instr[$];
  logic [`XLEN-1:0] q_pc[$];
  instr_word_u      stage_instr [`FETCH_SLOTS];
  logic [`XLEN-1:0] stage_pc    [`FETCH_SLOTS];
  int               stage_cnt;
  int               exp_pop;
  logic             strobed_last;
  logic [15:0]      lfsr;
  int               cycle_cnt = 0;
  int               issue_errors;
  int               count_errors;

  frontend_top dut_i (.*);

  always #20 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic is_alu_op(input logic [6:0] op);
    return (op == `OP_OP) || (op == `OP_IMM);
  endfunction

  function automatic instr_word_u random_instr();
    logic [1:0] sel;
    logic [6:0] op;
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [4:0] rd;
    logic [2:0] funct3;
    sel = 2'(take_bits(2));
    case (sel)
      2'd0:    op = `OP_OP;
      2'd1:    op = `OP_IMM;
      2'd2:    op = `OP_OP;
      default: op = 7'(take_bits(7));
    endcase
    // registers stay within x0..x3 so that pairs collide often.
    funct7 = 7'(take_bits(7));
    rs2    = 5'(take_bits(2));
    rs1    = 5'(take_bits(2));
    rd     = 5'(take_bits(2));
    funct3 = 3'(take_bits(3));
    if (op == `OP_IMM) begin
      rs2 = 5'(take_bits(5));
    end
    return {funct7, rs2, rs1, funct3, rd, op};
  endfunction

  // true when the second word reads a live destination of the first.
  function automatic logic depends_on_first(input logic [31:0] a, input logic [31:0] b);
    logic writes;
    logic reads1;
    logic reads2;
    writes = is_alu_op(a[6:0]) && (a[11:7] != 5'd0);
    reads1 = is_alu_op(b[6:0]) && (b[19:15] == a[11:7]);
    reads2 = (b[6:0] == `OP_OP) && (b[24:20] == a[11:7]);
    return writes && (reads1 || reads2);
  endfunction

  task automatic check_issue(input int slot, input logic exp_valid,
                             input instr_word_u exp_instr, input logic [`XLEN-1:0] exp_pc,
                             input logic [4:0] exp_rd, input logic [4:0] exp_rs1,
                             input logic [4:0] exp_rs2, input logic [`XLEN-1:0] exp_imm,
                             input logic exp_uses_imm);
    logic             act_valid;
    instr_word_u      act_instr;
    logic [`XLEN-1:0] act_pc;
    logic [4:0]       act_rd;
    logic [4:0]       act_rs1;
    logic [4:0]       act_rs2;
    logic [`XLEN-1:0] act_imm;
    logic             act_uses_imm;
    act_valid    = (slot == 0) ? issue0_valid : issue1_valid;
    act_instr    = (slot == 0) ? issue0_instr : issue1_instr;
    act_pc       = (slot == 0) ? issue0_pc : issue1_pc;
    act_rd       = (slot == 0) ? issue0_rd : issue1_rd;
    act_rs1      = (slot == 0) ? issue0_rs1 : issue1_rs1;
    act_rs2      = (slot == 0) ? issue0_rs2 : issue1_rs2;
    act_imm      = (slot == 0) ? issue0_imm : issue1_imm;
    act_uses_imm = (slot == 0) ? issue0_uses_imm : issue1_uses_imm;
    if (act_valid !== exp_valid) begin
      issue_errors++;
      $display("** Error @ %0t: slot %0d valid is %b, expected %b",
               $time, slot, act_valid, exp_valid);
    end else if (exp_valid && ({act_instr, act_pc, act_rd, act_rs1, act_rs2, act_imm,
                                act_uses_imm} !== {exp_instr, exp_pc, exp_rd, exp_rs1,
                                exp_rs2, exp_imm, exp_uses_imm})) begin
      issue_errors++;
      $display("** Error @ %0t: slot %0d got instr %h pc %h rd %0d rs1 %0d rs2 %0d imm %h u %b",
               $time, slot, act_instr, act_pc, act_rd, act_rs1, act_rs2, act_imm, act_uses_imm);
      $display("    expected instr %h pc %h rd %0d rs1 %0d rs2 %0d imm %h u %b",
               exp_instr, exp_pc, exp_rd, exp_rs1, exp_rs2, exp_imm, exp_uses_imm);
    end
  endtask

  task automatic check_count(input logic [`IB_DEPTH_LOG2:0] exp_count);
    if (buf_count !== exp_count) begin
      count_errors++;
      $display("** Error @ %0t: buf_count is %0d, expected %0d", $time, buf_count, exp_count);
    end
  endtask

  // decodes the model entry straight from the instruction bit positions.
  task automatic expect_slot(input int slot, input logic valid, input int idx);
    logic [31:0]      w;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    w  = '0;
    pc = '0;
    if (valid) begin
      w  = q_instr[idx];
      pc = q_pc[idx];
    end
    imm = (w[6:0] == `OP_IMM) ? {{20{w[31]}}, w[31:20]} : '0;
    check_issue(slot, valid, w, pc, w[11:7], w[19:15], w[24:20], imm, w[6:0] == `OP_IMM);
  endtask

  // outputs are settled at the falling edge.
  always @(negedge clk) begin
    int   n;
    logic e0;
    logic e1;
    logic blocked;
    if (!rst_n) begin
      exp_pop = 0;
    end else begin
      n       = q_pc.size();
      blocked = 1'b0;
      if (n >= 2) begin
        blocked = depends_on_first(q_instr[0], q_instr[1]);
      end
      e0 = issue_ready && (n >= 1);
      e1 = e0 && (n >= 2) && !blocked;
      expect_slot(0, e0, 0);
      expect_slot(1, e1, 1);
      check_count((`IB_DEPTH_LOG2+1)'(n));
      exp_pop = int'(e0) + int'(e1);
    end
  end

  always @(posedge clk) begin
    int                            ofs;
    logic                          coin;
    logic [`FETCH_SLOTS*`XLEN-1:0] blk;
    logic [`XLEN-1:0]              pc;
    cycle_cnt++;
    // model update from the inputs the DUT samples at this edge.
    if (!rst_n || flush) begin
      q_instr.delete();
      q_pc.delete();
      stage_cnt = 0;
    end else begin
      for (int i = 0; i < exp_pop; i++) begin
        void'(q_instr.pop_front());
        void'(q_pc.pop_front());
      end
      for (int i = 0; i < stage_cnt; i++) begin
        q_instr.push_back(stage_instr[i]);
        q_pc.push_back(stage_pc[i]);
      end
      stage_cnt = 0;
      if (fetch_valid) begin
        ofs       = int'(fetch_pc[3:2]);
        stage_cnt = `FETCH_SLOTS - ofs;
        for (int j = 0; j < stage_cnt; j++) begin
          stage_instr[j] = fetch_block[`XLEN*(ofs+j) +: `XLEN];
          stage_pc[j]    = fetch_pc + 32'(4 * j);
        end
      end
    end
    if (!rst_n) begin
      fetch_valid  <= 1'b0;
      flush        <= 1'b0;
      issue_ready  <= 1'b0;
      strobed_last = 1'b0;
    end else begin
      coin = 1'(take_bits(1));
      // room is counted against the queue plus the block still in the aligner.
      if (coin && !strobed_last && (q_pc.size() + stage_cnt + 4 <= `IB_DEPTH)) begin
        for (int s = 0; s < `FETCH_SLOTS; s++) begin
          blk[`XLEN*s +: `XLEN] = random_instr();
        end
        pc = {28'(take_bits(28)), 4'b0000};
        pc[3:2] = 2'(take_bits(2));
        fetch_pc     <= pc;
        fetch_block  <= blk;
        fetch_valid  <= 1'b1;
        strobed_last = 1'b1;
      end else begin
        fetch_valid  <= 1'b0;
        strobed_last = 1'b0;
      end
      issue_ready <= (take_bits(2) != 0);
      flush       <= (take_bits(6) == 0);
    end
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    fetch_valid  = 1'b0;
    fetch_pc     = '0;
    fetch_block  = '0;
    issue_ready  = 1'b0;
    lfsr         = SEED;
    stage_cnt    = 0;
    exp_pop      = 0;
    strobed_last = 1'b0;
    issue_errors = 0;
    count_errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (RUN_CYCLES) @(posedge clk);
    $display("errors: issue %0d, count %0d", issue_errors, count_errors);
    if (issue_errors == 0 && count_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- build.f
+incdir+design
design/frontend_pkg.sv
design/fetch_align.sv
design/instr_buffer.sv
design/pair_decoder.sv
design/frontend_top.sv
testbench/tb_frontend.sv

//--- Bender.yml
package:
  name: frontend

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/frontend_pkg.sv
      - design/fetch_align.sv
      - design/instr_buffer.sv
      - design/pair_decoder.sv
      - design/frontend_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_frontend.sv
